// ==== include/keypad_macros.svh ====
`ifndef KEYPAD_MACROS_SVH
`define KEYPAD_MACROS_SVH

// 5-bit lfsr gives the settle pacer a tick every 31 cycles
`define KEYPAD_PACER_WIDTH 5
// feedback taps for x^5 + x^3 + 1
`define KEYPAD_PACER_TAPS 5'b10100

// equal single-key scans before a key is accepted
`define KEYPAD_DEBOUNCE_SCANS 3

// key code queue entries
`define KEYPAD_FIFO_DEPTH 4

// axi4-lite byte offsets
`define KEYPAD_REG_STATUS 4'h0
`define KEYPAD_REG_KEY 4'h4
`define KEYPAD_REG_CONTROL 4'h8

`endif

// ==== logic/keypadPkg.sv ====
package keypadPkg;

    // 0-9 digits, 10 A, 11 B, 12 *, 13 #, 14 C, 15 D
    typedef logic [3:0] keyCode_t;

    // active low with one bit per row
    typedef logic [3:0] rowBits_t;

    // active low with one bit per column
    typedef logic [3:0] colBits_t;

    // one full scan with column c in bits 4c+3:4c
    typedef logic [15:0] scanImage_t;

    typedef logic [1:0] axiResp_t;

    localparam axiResp_t respOkay = 2'b00;
    localparam axiResp_t respSlvErr = 2'b10;

    // scanner fsm
    typedef enum logic [1:0] {
        scanColumns = 2'b00, // walking the columns
        judgeScan = 2'b01,   // one cycle to classify the scan
        offerKey = 2'b10     // key code waits for the fifo
    } scanState_t;

endpackage

// ==== logic/settlePacer.sv ====
`timescale 1ns/1ps
`include "keypad_macros.svh"

module settlePacer (
    input  logic Clock,
    input  logic Reset,
    input  logic restart,
    output logic settleTick
);

    localparam int lfsrWidth = `KEYPAD_PACER_WIDTH;
    localparam logic [lfsrWidth-1:0] lfsrSeed = '1;
    localparam logic [lfsrWidth-1:0] lfsrTaps = `KEYPAD_PACER_TAPS;

    logic [lfsrWidth-1:0] lfsr;
    logic [lfsrWidth-1:0] lfsrNext;
    logic feedback;

    // fibonacci form whose all-ones seed keeps it off the lock-up state
    assign feedback = ^(lfsr & lfsrTaps);
    assign lfsrNext = {lfsr[lfsrWidth-2:0], feedback};

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            lfsr       <= lfsrSeed;
            settleTick <= 1'b0;
        end else if (restart) begin
            lfsr       <= lfsrSeed;  // period starts over
            settleTick <= 1'b0;
        end else begin
            lfsr       <= lfsrNext;
            settleTick <= (lfsrNext == lfsrSeed);  // back at seed after one full period
        end
    end

endmodule

// ==== logic/keypadScanner.sv ====
`timescale 1ns/1ps
`include "keypad_macros.svh"

module keypadScanner import keypadPkg::*; (
    input  logic     Clock,
    input  logic     Reset,
    input  logic     scanEnable,
    input  logic     settleTick,
    output logic     pacerRestart,
    input  rowBits_t RowIn,
    output colBits_t ColOut,
    output logic     keyValid,
    input  logic     keyAccept,
    output keyCode_t keyCode
);

    localparam int countWidth = $clog2(`KEYPAD_DEBOUNCE_SCANS + 1);

    typedef logic [countWidth-1:0] scanCount_t;

    localparam scanCount_t debounceScans = scanCount_t'(`KEYPAD_DEBOUNCE_SCANS);

    scanState_t state;
    logic [1:0] colSel;      // column being scanned
    logic       halfDone;    // settle tick already seen
    logic       armed;       // a keyless scan came first
    scanCount_t sameCount;
    scanCount_t nextCount;
    scanImage_t scanImage;
    scanImage_t candidate;
    scanImage_t pressed;
    colBits_t   colDrive;
    logic       noKey;
    logic       singleKey;
    logic       debounced;

    function automatic keyCode_t codeOf(input scanImage_t hit);
        keyCode_t code;
        code = 4'd0;
        case (hit)
            16'h0001: code = 4'd1;
            16'h0002: code = 4'd4;
            16'h0004: code = 4'd7;
            16'h0008: code = 4'd12;  // *
            16'h0010: code = 4'd2;
            16'h0020: code = 4'd5;
            16'h0040: code = 4'd8;
            16'h0080: code = 4'd0;
            16'h0100: code = 4'd3;
            16'h0200: code = 4'd6;
            16'h0400: code = 4'd9;
            16'h0800: code = 4'd13;  // #
            16'h1000: code = 4'd10;  // A
            16'h2000: code = 4'd11;  // B
            16'h4000: code = 4'd14;  // C
            16'h8000: code = 4'd15;  // D
            default:  code = 4'd0;
        endcase
        return code;
    endfunction

    assign pacerRestart = !scanEnable || (state == offerKey);

    // one column low while scanning and all released otherwise
    assign colDrive = (state == scanColumns && scanEnable) ?
                      ~(colBits_t'(1) << colSel) : '1;

    for (genvar c = 0; c < 4; c++) begin : gColDrive
        assign ColOut[c] = colDrive[c] ? 1'bz : 1'b0;  // open drain
    end

    assign pressed   = ~scanImage;  // high bit per pressed key
    assign noKey     = (pressed == '0);
    assign singleKey = !noKey && ((pressed & (pressed - 1'b1)) == '0);
    assign nextCount = (pressed == candidate) ? sameCount + 1'b1 : scanCount_t'(1);
    assign debounced = armed && singleKey && (nextCount == debounceScans);

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            state     <= scanColumns;
            colSel    <= '0;
            halfDone  <= 1'b0;
            armed     <= 1'b0;
            sameCount <= '0;
            candidate <= '0;
            keyValid  <= 1'b0;
        end else begin
            case (state)
                scanColumns: begin
                    if (!scanEnable) begin
                        colSel   <= '0;
                        halfDone <= 1'b0;
                    end else if (settleTick) begin
                        if (!halfDone) begin
                            halfDone <= 1'b1;
                        end else begin
                            halfDone <= 1'b0;
                            colSel   <= colSel + 1'b1;
                            if (colSel == 2'd3) begin
                                state <= judgeScan;
                            end
                        end
                    end
                end
                judgeScan: begin
                    state <= scanColumns;
                    if (noKey) begin
                        armed <= 1'b1;
                    end else if (!singleKey) begin
                        armed     <= 1'b0;  // several keys start over
                        sameCount <= '0;
                    end else if (armed) begin
                        candidate <= pressed;
                        if (debounced) begin
                            sameCount <= '0;
                            keyValid  <= 1'b1;
                            state     <= offerKey;
                        end else begin
                            sameCount <= nextCount;
                        end
                    end
                end
                offerKey: begin
                    if (keyAccept) begin
                        keyValid <= 1'b0;
                        armed    <= 1'b0;  // needs a release before the next key
                        state    <= scanColumns;
                    end
                end
                default: state <= scanColumns;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == scanColumns && scanEnable && settleTick && halfDone) begin
            scanImage[{colSel, 2'b00} +: 4] <= RowIn;  // sample tick
        end
        if (state == judgeScan && debounced) begin
            keyCode <= codeOf(pressed);
        end
    end

endmodule

// ==== logic/keyFifo.sv ====
`timescale 1ns/1ps
`include "keypad_macros.svh"

module keyFifo import keypadPkg::*; (
    input  logic       Clock,
    input  logic       Reset,
    input  logic       pushKey,
    input  keyCode_t   pushCode,
    input  logic       popKey,
    output keyCode_t   headCode,
    output logic       notFull,
    output logic [2:0] fillCount
);

    localparam int depth = `KEYPAD_FIFO_DEPTH;
    localparam int ptrWidth = $clog2(depth);

    keyCode_t            slots [depth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [2:0]          count;
    logic                doPush;
    logic                doPop;

    function automatic logic [ptrWidth-1:0] bump(input logic [ptrWidth-1:0] ptr);
        return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign notFull   = (count != 3'(depth));
    assign doPush    = pushKey && notFull;
    assign doPop     = popKey && (count != 3'd0);  // pop on empty is ignored
    assign headCode  = slots[rdPtr];
    assign fillCount = count;

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= bump(wrPtr);
            if (doPop) rdPtr <= bump(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (doPush) begin
            slots[wrPtr] <= pushCode;
        end
    end

endmodule

// ==== logic/keypadAxiRegs.sv ====
`timescale 1ns/1ps
`include "keypad_macros.svh"

module keypadAxiRegs import keypadPkg::*; (
    input  logic        Clock,
    input  logic        Reset,
    input  logic [3:0]  AWADDR,
    input  logic        AWVALID,
    output logic        AWREADY,
    input  logic [31:0] WDATA,
    input  logic        WVALID,
    output logic        WREADY,
    output axiResp_t    BRESP,
    output logic        BVALID,
    input  logic        BREADY,
    input  logic [3:0]  ARADDR,
    input  logic        ARVALID,
    output logic        ARREADY,
    output logic [31:0] RDATA,
    output axiResp_t    RRESP,
    output logic        RVALID,
    input  logic        RREADY,
    input  keyCode_t    headCode,
    input  logic [2:0]  fillCount,
    output logic        popKey,
    output logic        scanEnable
);

    logic        keyAvail;
    logic        readShake;
    logic        writeShake;
    logic        writeOk;
    logic [31:0] readData;
    axiResp_t    readResp;

    assign keyAvail = (fillCount != 3'd0);

    assign ARREADY   = !RVALID;  // one read in flight
    assign readShake = ARVALID && ARREADY;
    assign popKey    = readShake && (ARADDR == `KEYPAD_REG_KEY) && keyAvail;

    // aw and w taken together
    assign writeShake = AWVALID && WVALID && !BVALID;
    assign AWREADY    = writeShake;
    assign WREADY     = writeShake;
    assign writeOk    = (AWADDR == `KEYPAD_REG_CONTROL);  // only writable register

    always_comb begin
        readData = '0;
        readResp = respOkay;
        case (ARADDR)
            `KEYPAD_REG_STATUS: readData = {28'd0, fillCount, keyAvail};
            `KEYPAD_REG_KEY: begin
                if (keyAvail) begin
                    readData = {23'd0, 1'b1, 4'd0, headCode};  // bit 8 valid
                end
            end
            `KEYPAD_REG_CONTROL: readData = {31'd0, scanEnable};
            default: readResp = respSlvErr;
        endcase
    end

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            RVALID     <= 1'b0;
            BVALID     <= 1'b0;
            scanEnable <= 1'b0;
        end else begin
            if (readShake) begin
                RVALID <= 1'b1;
            end else if (RREADY) begin
                RVALID <= 1'b0;
            end
            if (writeShake) begin
                BVALID <= 1'b1;
            end else if (BREADY) begin
                BVALID <= 1'b0;
            end
            if (writeShake && writeOk) begin
                scanEnable <= WDATA[0];
            end
        end
    end

    // response payload held while valid waits for ready
    always_ff @(posedge Clock) begin
        if (readShake) begin
            RDATA <= readData;
            RRESP <= readResp;
        end
        if (writeShake) begin
            BRESP <= writeOk ? respOkay : respSlvErr;
        end
    end

endmodule

// ==== logic/keypadTop.sv ====
`timescale 1ns/1ps

module keypadTop import keypadPkg::*; (
    input  logic        Clock,
    input  logic        Reset,
    input  rowBits_t    RowIn,
    output colBits_t    ColOut,
    input  logic [3:0]  AWADDR,
    input  logic        AWVALID,
    output logic        AWREADY,
    input  logic [31:0] WDATA,
    input  logic        WVALID,
    output logic        WREADY,
    output axiResp_t    BRESP,
    output logic        BVALID,
    input  logic        BREADY,
    input  logic [3:0]  ARADDR,
    input  logic        ARVALID,
    output logic        ARREADY,
    output logic [31:0] RDATA,
    output axiResp_t    RRESP,
    output logic        RVALID,
    input  logic        RREADY
);

    logic       settleTick;
    logic       pacerRestart;
    logic       scanEnable;
    logic       keyValid;
    logic       notFull;   // doubles as keyAccept
    logic       popKey;
    keyCode_t   keyCode;
    keyCode_t   headCode;
    logic [2:0] fillCount;

    settlePacer settlePacer_i (
        .Clock      (Clock),
        .Reset      (Reset),
        .restart    (pacerRestart),
        .settleTick (settleTick)
    );

    keypadScanner keypadScanner_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .scanEnable   (scanEnable),
        .settleTick   (settleTick),
        .pacerRestart (pacerRestart),
        .RowIn        (RowIn),
        .ColOut       (ColOut),
        .keyValid     (keyValid),
        .keyAccept    (notFull),
        .keyCode      (keyCode)
    );

    keyFifo keyFifo_i (
        .Clock     (Clock),
        .Reset     (Reset),
        .pushKey   (keyValid),
        .pushCode  (keyCode),
        .popKey    (popKey),
        .headCode  (headCode),
        .notFull   (notFull),
        .fillCount (fillCount)
    );

    keypadAxiRegs keypadAxiRegs_i (
        .Clock      (Clock),
        .Reset      (Reset),
        .AWADDR     (AWADDR),
        .AWVALID    (AWVALID),
        .AWREADY    (AWREADY),
        .WDATA      (WDATA),
        .WVALID     (WVALID),
        .WREADY     (WREADY),
        .BRESP      (BRESP),
        .BVALID     (BVALID),
        .BREADY     (BREADY),
        .ARADDR     (ARADDR),
        .ARVALID    (ARVALID),
        .ARREADY    (ARREADY),
        .RDATA      (RDATA),
        .RRESP      (RRESP),
        .RVALID     (RVALID),
        .RREADY     (RREADY),
        .headCode   (headCode),
        .fillCount  (fillCount),
        .popKey     (popKey),
        .scanEnable (scanEnable)
    );

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic Clock,
    output logic Reset
);

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;  // 8 ns period
    end

    initial begin
        Reset = 1'b0;
        repeat (16) @(posedge Clock);
        #1 Reset = 1'b1;  // released just after the 16th edge
    end

endmodule

// ==== testbench/keypad_assertions.sv ====
`timescale 1ns/1ps

module keypadAssertions import keypadPkg::*; (
    input logic     Clock,
    input logic     Reset,
    input logic     RVALID,
    input logic     RREADY,
    input logic     BVALID,
    input logic     BREADY,
    input logic     keyValid,
    input logic     keyAccept,
    input colBits_t ColOut
);

    int failCount = 0;  // read by the testbench at the end
    logic [3:0] colLow;

    assign colLow = {ColOut[3] === 1'b0, ColOut[2] === 1'b0,
                     ColOut[1] === 1'b0, ColOut[0] === 1'b0};

    property heldUntilReady(logic valid, logic ready);
        @(posedge Clock) disable iff (!Reset) valid && !ready |=> valid;
    endproperty

    rValidHeld: assert property (heldUntilReady(RVALID, RREADY)) else begin
        failCount++;
        $error("RVALID dropped before RREADY");
    end

    bValidHeld: assert property (heldUntilReady(BVALID, BREADY)) else begin
        failCount++;
        $error("BVALID dropped before BREADY");
    end

    keyValidHeld: assert property (heldUntilReady(keyValid, keyAccept)) else begin
        failCount++;
        $error("keyValid dropped before keyAccept");
    end

    oneColumnLow: assert property (@(posedge Clock) disable iff (!Reset)
                                   $countones(colLow) <= 1) else begin
        failCount++;
        $error("more than one column driven low");
    end

endmodule

bind keypadTop keypadAssertions keypadAssertions_i (
    .Clock     (Clock),
    .Reset     (Reset),
    .RVALID    (RVALID),
    .RREADY    (RREADY),
    .BVALID    (BVALID),
    .BREADY    (BREADY),
    .keyValid  (keyValid),
    .keyAccept (notFull),
    .ColOut    (ColOut)
);

// ==== testbench/keypadTb.sv ====
`timescale 1ns/1ps
`include "keypad_macros.svh"

module keypadTb import keypadPkg::*; ();

    localparam int scanCycles = 8 * ((1 << `KEYPAD_PACER_WIDTH) - 1);  // two ticks per column
    localparam int holdScans = `KEYPAD_DEBOUNCE_SCANS + 2;
    localparam int tableRows = 18;
    localparam int extraPresses = `KEYPAD_FIFO_DEPTH + 2;  // disabled press and fifo fill

    logic        Clock;
    logic        Reset;
    wire  [3:0]  rowLines;
    wire  [3:0]  colLines;
    logic [15:0] heldKeys;  // bit 4*row+col
    logic [3:0]  rowLow;
    logic [3:0]  AWADDR;
    logic [3:0]  ARADDR;
    logic [31:0] WDATA;
    logic        AWVALID, WVALID, BREADY, ARVALID, RREADY;
    logic        AWREADY, WREADY, BVALID, ARREADY, RVALID;
    axiResp_t    BRESP;
    axiResp_t    RRESP;
    logic [31:0] RDATA;
    logic [31:0] rdData;
    axiResp_t    resp;
    int          errors = 0;
    int          rowCount = 0;
    logic [15:0] tblMask [tableRows];
    int          tblHold [tableRows];
    int          tblCode [tableRows];  // -1 when no code may appear
    // code per key position 4*row+col
    keyCode_t    layout [16] = '{4'd1, 4'd2, 4'd3, 4'd10, 4'd4, 4'd5, 4'd6, 4'd11,
                                 4'd7, 4'd8, 4'd9, 4'd14, 4'd12, 4'd0, 4'd13, 4'd15};

    clockGen clockGen_i (.Clock(Clock), .Reset(Reset));

    keypadTop keypadTop_i (.RowIn(rowLines), .ColOut(colLines), .*);

    for (genvar r = 0; r < 4; r++) begin : gKeypad
        pullup (rowLines[r]);
        pullup (colLines[r]);
        assign rowLines[r] = rowLow[r] ? 1'b0 : 1'bz;
    end

    // a held key shorts its row to a column that is pulled low
    always_comb begin
        rowLow = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (heldKeys[4 * r + c] && colLines[c] === 1'b0) rowLow[r] = 1'b1;
            end
        end
    end

    task automatic stepCycle();
        @(posedge Clock);
        #1;
    endtask

    task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            errors++;
            $display("mismatch %s got 0x%0h expected 0x%0h", name, got, want);
        end
    endtask

    task automatic addRow(input logic [15:0] mask, input int hold, input int code);
        tblMask[rowCount] = mask;
        tblHold[rowCount] = hold;
        tblCode[rowCount] = code;
        rowCount++;
    endtask

    task automatic readReg(input logic [3:0] addr, input int stall,
                           output logic [31:0] data, output axiResp_t rresp);
        logic [31:0] first;
        stepCycle();
        ARADDR  = addr;
        ARVALID = 1'b1;
        while (!ARREADY) stepCycle();
        stepCycle();  // address taken on this edge
        ARVALID = 1'b0;
        while (!RVALID) stepCycle();
        first = RDATA;
        repeat (stall) begin
            stepCycle();
            expectEq("RDATA", RDATA, first);
        end
        data   = RDATA;
        rresp  = RRESP;
        RREADY = 1'b1;
        stepCycle();
        RREADY = 1'b0;
    endtask

    task automatic writeReg(input logic [3:0] addr, input logic [31:0] data,
                            output axiResp_t bresp);
        stepCycle();
        AWADDR  = addr;
        WDATA   = data;
        AWVALID = 1'b1;
        WVALID  = 1'b1;
        #1;  // ready follows valid combinationally
        while (!AWREADY) begin
            stepCycle();
            #1;
        end
        expectEq("WREADY", WREADY, 32'h1);  // rises together with AWREADY
        stepCycle();
        AWVALID = 1'b0;
        WVALID  = 1'b0;
        while (!BVALID) stepCycle();
        bresp  = BRESP;
        BREADY = 1'b1;
        stepCycle();
        BREADY = 1'b0;
    endtask

    // hold, release for two scans so the scanner re-arms, then a random gap
    task automatic pressKey(input logic [15:0] mask, input int scans);
        heldKeys = mask;
        repeat (scans * scanCycles) stepCycle();
        heldKeys = '0;
        repeat (2 * scanCycles + $urandom % 64) stepCycle();
    endtask

    task automatic awaitKey();
        int polls;
        polls = 0;
        do begin
            readReg(`KEYPAD_REG_STATUS, 0, rdData, resp);
            polls++;
        end while (!rdData[0] && polls < scanCycles);
        assert (rdData[0]) else begin
            errors++;
            $display("no key showed up in STATUS while polling");
        end
    endtask

    initial begin
        int assertErrors;
        void'($urandom(62909));
        heldKeys = '0;
        AWADDR   = '0;
        ARADDR   = '0;
        WDATA    = '0;
        AWVALID  = 1'b0;
        WVALID   = 1'b0;
        BREADY   = 1'b0;
        ARVALID  = 1'b0;
        RREADY   = 1'b0;
        for (int k = 0; k < 16; k++) addRow(16'(1) << k, holdScans, layout[k]);
        addRow(16'h0020, 20, layout[5]);  // held on yet only one code
        addRow(16'h0021, holdScans, -1);  // two keys at once
        @(posedge Reset);
        stepCycle();

        // scanning still disabled
        readReg(`KEYPAD_REG_STATUS, 0, rdData, resp);
        expectEq("STATUS", rdData, 32'h0);
        readReg(`KEYPAD_REG_CONTROL, 0, rdData, resp);
        expectEq("CONTROL", rdData, 32'h0);
        pressKey(16'h0001, 6);
        readReg(`KEYPAD_REG_STATUS, 0, rdData, resp);
        expectEq("STATUS", rdData, 32'h0);
        writeReg(`KEYPAD_REG_CONTROL, 32'h1, resp);
        expectEq("BRESP", resp, 32'h0);
        readReg(`KEYPAD_REG_CONTROL, 0, rdData, resp);
        expectEq("CONTROL", rdData, 32'h1);
        repeat (2 * scanCycles) stepCycle();  // a keyless scan arms the scanner

        for (int i = 0; i < rowCount; i++) begin
            pressKey(tblMask[i], tblHold[i]);
            if (tblCode[i] >= 0) begin
                awaitKey();
                readReg(`KEYPAD_REG_KEY, 0, rdData, resp);
                expectEq("KEY", rdData, 32'h100 | tblCode[i]);
            end
            readReg(`KEYPAD_REG_STATUS, 0, rdData, resp);
            expectEq("STATUS", rdData, 32'h0);
        end

        // one more key than the fifo holds
        for (int k = 0; k <= `KEYPAD_FIFO_DEPTH; k++) pressKey(16'(1) << k, holdScans);
        awaitKey();
        expectEq("STATUS", rdData, (`KEYPAD_FIFO_DEPTH << 1) | 1);
        for (int k = 0; k <= `KEYPAD_FIFO_DEPTH; k++) begin
            readReg(`KEYPAD_REG_KEY, 0, rdData, resp);
            expectEq("KEY", rdData, 32'h100 | layout[k]);
        end
        readReg(`KEYPAD_REG_KEY, 0, rdData, resp);
        expectEq("KEY", rdData, 32'h0);
        expectEq("RRESP", resp, 32'h0);

        readReg(4'hC, 0, rdData, resp);
        expectEq("RRESP", resp, 32'h2);
        writeReg(`KEYPAD_REG_STATUS, 32'h1, resp);
        expectEq("BRESP", resp, 32'h2);
        writeReg(`KEYPAD_REG_KEY, 32'h1, resp);
        expectEq("BRESP", resp, 32'h2);
        writeReg(`KEYPAD_REG_CONTROL, 32'h1, resp);
        expectEq("BRESP", resp, 32'h0);
        repeat (4) begin
            readReg(`KEYPAD_REG_CONTROL, $urandom % 16, rdData, resp);
            expectEq("CONTROL", rdData, 32'h1);
        end

        assertErrors = keypadTop_i.keypadAssertions_i.failCount;
        $display("errors: %0d checks, %0d assertions", errors, assertErrors);
        if (errors == 0 && assertErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // eight scans per press plus slack for reset and bus traffic
    initial begin
        repeat ((tableRows + extraPresses) * 8 * scanCycles + 5000) @(posedge Clock);
        $display("timeout, the test sequence did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
logic/keypadPkg.sv
logic/settlePacer.sv
logic/keypadScanner.sv
logic/keyFifo.sv
logic/keypadAxiRegs.sv
logic/keypadTop.sv
testbench/clockGen.sv
testbench/keypad_assertions.sv
testbench/keypadTb.sv

// ==== Bender.yml ====
package:
  name: keypad_frontend

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/keypadPkg.sv
      - logic/settlePacer.sv
      - logic/keypadScanner.sv
      - logic/keyFifo.sv
      - logic/keypadAxiRegs.sv
      - logic/keypadTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/clockGen.sv
      - testbench/keypad_assertions.sv
      - testbench/keypadTb.sv
